// File: hw/crd_pkg.sv
package crd_pkg;

  // --------------------
  // Link constants

  // Flow classes carried on every VC
  localparam int NUM_FC = 3;

  // External VCs covered by the map register
  localparam int NUM_MAP_VCS = 8;

  // Valid bit inside each map nibble
  localparam int MAP_VALID_BIT = 3;

  // Data credits a used channel needs before traffic may start
  localparam int MIN_DATA_CRD = 4;

  // Same mask on every VC, all flow classes in use
  localparam logic [NUM_FC-1:0] FC_USED = 3'b111;

  // --------------------
  // Credit types

  typedef logic [1:0]  fc_id_t;
  typedef logic [4:0]  ext_vc_t;

  // Eight nibbles, one per external VC
  typedef logic [31:0] rxmap_t;

  // Returned credit values, zero means infinite
  typedef logic [3:0]  hdr_rtn_t;
  typedef logic [3:0]  data_rtn_t;

  // One header credit per consume
  typedef logic        hdr_use_t;
  // Up to four data credits per consume
  typedef logic [2:0]  data_use_t;

  // Flow class 3 is not defined on the link
  localparam fc_id_t FC_ILLEGAL = 2'd3;

  // Internal VC index width, never below one bit
  function automatic int vc_idx_w(int num_vcs);
    return (num_vcs > 1) ? $clog2(num_vcs) : 1;
  endfunction

endpackage

// File: hw/crd_rtn_decode.sv
module crd_rtn_decode
  import crd_pkg::*;
#(
  parameter int NUM_VCS = 2,
  localparam int VC_W = vc_idx_w(NUM_VCS)
) (
  input  logic            clk_gated,
  input  logic            rst_b,
  input  logic            tx_sm_disconnected,
  input  rxmap_t          cfg_vc_rxmap,
  input  logic            rx_empty,

  // Fabric header credit return
  input  logic            hdr_rtn_valid,
  input  ext_vc_t         hdr_rtn_vc_id,
  input  fc_id_t          hdr_rtn_fc,

  // Fabric data credit return
  input  logic            data_rtn_valid,
  input  ext_vc_t         data_rtn_vc_id,
  input  fc_id_t          data_rtn_fc,

  // Mapped returns toward the counter banks
  output logic            hdr_rtn_v,
  output logic [VC_W-1:0] hdr_rtn_vc,
  output logic            data_rtn_v,
  output logic [VC_W-1:0] data_rtn_vc,

  output logic            rx_empty_seen
);

  logic [3:0] hdr_nib;
  logic [3:0] data_nib;

  // Map nibble holds only three VC bits
  if (VC_W > 3) begin : g_vc_w_check
    $error("crd_rtn_decode supports at most 8 internal VCs");
  end

  // --------------------
  // Return mapping

  // Nibble of the external VC, low three id bits select it
  assign hdr_nib  = cfg_vc_rxmap[{hdr_rtn_vc_id[2:0], 2'b00} +: 4];
  assign data_nib = cfg_vc_rxmap[{data_rtn_vc_id[2:0], 2'b00} +: 4];

  // Only external VCs 0..7 with a set valid bit are ours
  // Fabric may announce credits for channels we never use
  assign hdr_rtn_v  = hdr_rtn_valid & (hdr_rtn_vc_id < NUM_MAP_VCS) &
                      hdr_nib[MAP_VALID_BIT];
  assign data_rtn_v = data_rtn_valid & (data_rtn_vc_id < NUM_MAP_VCS) &
                      data_nib[MAP_VALID_BIT];

  // Internal VC from the low nibble bits, truncated to index width
  assign hdr_rtn_vc  = hdr_nib[VC_W-1:0];
  assign data_rtn_vc = data_nib[VC_W-1:0];

  // --------------------
  // Receiver empty tracking

  // Sets on the first rx_empty while connected
  // Held until the link drops back to disconnected
  always_ff @(posedge clk_gated or negedge rst_b) begin
    if (!rst_b) begin
      rx_empty_seen <= 1'b0;
    end else if (tx_sm_disconnected) begin
      rx_empty_seen <= 1'b0;
    end else if (rx_empty) begin
      rx_empty_seen <= 1'b1;
    end
  end

  // Banks index counters by flow class, an illegal one would be lost
  a_hdr_rtn_fc: assert property (@(posedge clk_gated) disable iff (!rst_b)
    hdr_rtn_v |-> hdr_rtn_fc != FC_ILLEGAL);

  a_data_rtn_fc: assert property (@(posedge clk_gated) disable iff (!rst_b)
    data_rtn_v |-> data_rtn_fc != FC_ILLEGAL);

endmodule

// File: hw/crd_counter_bank.sv
module crd_counter_bank
  import crd_pkg::*;
#(
  parameter int  NUM_VCS = 2,
  parameter int  CNT_W   = 8,
  parameter type inc_t   = hdr_rtn_t,
  parameter type dec_t   = hdr_use_t,
  localparam int VC_W    = vc_idx_w(NUM_VCS)
) (
  input  logic                                   clk_gated,
  input  logic                                   rst_b,
  input  logic                                   tx_sm_disconnected,
  input  logic                                   rx_empty_seen,

  // Mapped fabric return
  input  logic                                   rtn_v,
  input  logic [VC_W-1:0]                        rtn_vc,
  input  fc_id_t                                 rtn_fc,
  input  inc_t                                   rtn_value,

  // Transmitter consume
  input  logic                                   use_v,
  input  logic [VC_W-1:0]                        use_vc,
  input  fc_id_t                                 use_fc,
  input  dec_t                                   use_value,

  output logic [NUM_VCS-1:0][NUM_FC-1:0][CNT_W-1:0] crd_cnt,
  output logic [NUM_VCS-1:0][NUM_FC-1:0]            crd_inf,
  output logic                                   has_consumed,
  output logic                                   used_xflow
);

  // One spare bit catches saturation and consumed carry
  localparam int SUM_W = CNT_W + 1;

  inc_t [NUM_VCS-1:0][NUM_FC-1:0]                inc_amt;
  dec_t [NUM_VCS-1:0][NUM_FC-1:0]                dec_amt;
  logic [NUM_VCS-1:0][NUM_FC-1:0][SUM_W-1:0]     cnt_sum;
  logic [NUM_VCS-1:0][NUM_FC-1:0][CNT_W-1:0]     cnt_next;
  logic [NUM_VCS-1:0][NUM_FC-1:0]                inf_next;
  logic [NUM_VCS-1:0][NUM_FC-1:0][SUM_W-1:0]     cons_next;
  logic [NUM_VCS-1:0][NUM_FC-1:0][CNT_W-1:0]     cons_q;
  logic [NUM_VCS-1:0][NUM_FC-1:0]                carry_q;

  // --------------------
  // Per channel next state

  always_comb begin
    inc_amt   = '0;
    dec_amt   = '0;
    cnt_sum   = '0;
    cnt_next  = crd_cnt;
    inf_next  = crd_inf;
    for (int v = 0; v < NUM_VCS; v++) begin
      for (int f = 0; f < NUM_FC; f++) begin
        cons_next[v][f] = {1'b0, cons_q[v][f]};

        // Infinite channels ignore both returns and consumes
        if (rtn_v && rtn_vc == v && rtn_fc == f && !crd_inf[v][f]) begin
          inc_amt[v][f] = rtn_value;
          // Zero value announces infinite credits
          if (rtn_value == '0) begin
            inf_next[v][f] = 1'b1;
          end
        end
        if (use_v && use_vc == v && use_fc == f && !crd_inf[v][f]) begin
          dec_amt[v][f] = use_value;
        end

        if (tx_sm_disconnected) begin
          // Counts restart from zero, consumed totals hold
          cnt_next[v][f] = '0;
        end else begin
          cnt_sum[v][f] = {1'b0, crd_cnt[v][f]} + SUM_W'(inc_amt[v][f]) -
                          SUM_W'(dec_amt[v][f]);
          // Top bit set means overflow, clamp at all ones
          if (cnt_sum[v][f][CNT_W]) begin
            cnt_next[v][f] = '1;
          end else begin
            cnt_next[v][f] = cnt_sum[v][f][CNT_W-1:0];
          end

          // Init credits arrive before rx_empty and must not count as returns
          if (rx_empty_seen) begin
            cons_next[v][f] = {1'b0, cons_q[v][f]} + SUM_W'(dec_amt[v][f]) -
                              SUM_W'(inc_amt[v][f]);
          end else begin
            cons_next[v][f] = {1'b0, cons_q[v][f]} + SUM_W'(dec_amt[v][f]);
          end
        end
      end
    end
  end

  // --------------------
  // Registers

  always_ff @(posedge clk_gated or negedge rst_b) begin
    if (!rst_b) begin
      crd_cnt <= '0;
      crd_inf <= '0;
      cons_q  <= '0;
      carry_q <= '0;
    end else begin
      crd_cnt <= cnt_next;
      crd_inf <= inf_next;
      for (int v = 0; v < NUM_VCS; v++) begin
        for (int f = 0; f < NUM_FC; f++) begin
          cons_q[v][f]  <= cons_next[v][f][CNT_W-1:0];
          // Carry of this cycle's update, wrap either way is an error
          carry_q[v][f] <= cons_next[v][f][CNT_W];
        end
      end
    end
  end

  // Outstanding credits anywhere in this bank
  assign has_consumed = |cons_q;
  assign used_xflow   = |carry_q;

  // Consume ports come straight from the transmitter
  a_use_fc: assert property (@(posedge clk_gated) disable iff (!rst_b)
    use_v |-> use_fc != FC_ILLEGAL);

endmodule

// File: hw/crd_min_check.sv
module crd_min_check
  import crd_pkg::*;
#(
  parameter int NUM_VCS = 2,
  parameter int CNT_W   = 8
) (
  input  logic                                      clk_gated,
  input  logic                                      rst_b,
  input  logic                                      rx_empty_seen,

  // Bank state
  input  logic [NUM_VCS-1:0][NUM_FC-1:0][CNT_W-1:0] hcrd_cnt,
  input  logic [NUM_VCS-1:0][NUM_FC-1:0][CNT_W-1:0] dcrd_cnt,
  input  logic [NUM_VCS-1:0][NUM_FC-1:0]            hcrd_inf,
  input  logic [NUM_VCS-1:0][NUM_FC-1:0]            dcrd_inf,
  input  logic                                      h_has_consumed,
  input  logic                                      d_has_consumed,

  output logic [NUM_VCS-1:0][NUM_FC-1:0][CNT_W-1:0] tx_hcrds_avail,
  output logic [NUM_VCS-1:0][NUM_FC-1:0][CNT_W-1:0] tx_dcrds_avail,
  output logic                                      tx_has_consumed_crds,
  output logic                                      tx_min_crds_rcvd
);

  logic [NUM_VCS-1:0][NUM_FC-1:0] min_hcrd;
  logic [NUM_VCS-1:0][NUM_FC-1:0] min_dcrd;
  logic                           min_next;

  // --------------------
  // Available credits

  always_comb begin
    for (int v = 0; v < NUM_VCS; v++) begin
      for (int f = 0; f < NUM_FC; f++) begin
        // Infinite reads all ones, nothing shows before rx_empty
        tx_hcrds_avail[v][f] = (hcrd_cnt[v][f] | {CNT_W{hcrd_inf[v][f]}}) &
                               {CNT_W{rx_empty_seen}};
        tx_dcrds_avail[v][f] = (dcrd_cnt[v][f] | {CNT_W{dcrd_inf[v][f]}}) &
                               {CNT_W{rx_empty_seen}};

        // Unused channels always pass
        min_hcrd[v][f] = !FC_USED[f] || (tx_hcrds_avail[v][f] != '0);
        min_dcrd[v][f] = !FC_USED[f] || (tx_dcrds_avail[v][f] >= MIN_DATA_CRD);
      end
    end
  end

  assign min_next = rx_empty_seen & (&min_hcrd) & (&min_dcrd);

  // --------------------
  // Minimum credit flag, one cycle behind the counts

  always_ff @(posedge clk_gated or negedge rst_b) begin
    if (!rst_b) begin
      tx_min_crds_rcvd <= 1'b0;
    end else begin
      tx_min_crds_rcvd <= min_next;
    end
  end

  assign tx_has_consumed_crds = h_has_consumed | d_has_consumed;

endmodule

// File: hw/crd_tx_top.sv
module crd_tx_top
  import crd_pkg::*;
#(
  parameter int NUM_VCS = 2,
  parameter int CNT_W   = 8,
  localparam int VC_W   = vc_idx_w(NUM_VCS)
) (
  input  logic                                      clk_gated,
  input  logic                                      rst_b,
  input  logic                                      tx_sm_disconnected,
  input  rxmap_t                                    cfg_vc_rxmap,
  input  logic                                      rx_empty,

  // Fabric credit returns
  input  logic                                      hdr_rtn_valid,
  input  ext_vc_t                                   hdr_rtn_vc_id,
  input  fc_id_t                                    hdr_rtn_fc,
  input  hdr_rtn_t                                  hdr_rtn_value,
  input  logic                                      data_rtn_valid,
  input  ext_vc_t                                   data_rtn_vc_id,
  input  fc_id_t                                    data_rtn_fc,
  input  data_rtn_t                                 data_rtn_value,

  // Transmitter consumes
  input  logic                                      tx_hcrd_consume_v,
  input  logic [VC_W-1:0]                           tx_hcrd_consume_vc,
  input  fc_id_t                                    tx_hcrd_consume_fc,
  input  hdr_use_t                                  tx_hcrd_consume_val,
  input  logic                                      tx_dcrd_consume_v,
  input  logic [VC_W-1:0]                           tx_dcrd_consume_vc,
  input  fc_id_t                                    tx_dcrd_consume_fc,
  input  data_use_t                                 tx_dcrd_consume_val,

  output logic [NUM_VCS-1:0][NUM_FC-1:0][CNT_W-1:0] tx_hcrds_avail,
  output logic [NUM_VCS-1:0][NUM_FC-1:0][CNT_W-1:0] tx_dcrds_avail,
  output logic                                      tx_has_consumed_crds,
  output logic                                      tx_min_crds_rcvd,
  output logic                                      tx_hcrds_used_xflow,
  output logic                                      tx_dcrds_used_xflow
);

  logic                                      hdr_rtn_v;
  logic [VC_W-1:0]                           hdr_rtn_vc;
  logic                                      data_rtn_v;
  logic [VC_W-1:0]                           data_rtn_vc;
  logic                                      rx_empty_seen;
  logic [NUM_VCS-1:0][NUM_FC-1:0][CNT_W-1:0] hcrd_cnt;
  logic [NUM_VCS-1:0][NUM_FC-1:0][CNT_W-1:0] dcrd_cnt;
  logic [NUM_VCS-1:0][NUM_FC-1:0]            hcrd_inf;
  logic [NUM_VCS-1:0][NUM_FC-1:0]            dcrd_inf;
  logic                                      h_has_consumed;
  logic                                      d_has_consumed;

  // --------------------
  // Return decode and receiver state

  crd_rtn_decode #(.NUM_VCS(NUM_VCS)) u_rtn_decode (
    .clk_gated, .rst_b, .tx_sm_disconnected, .cfg_vc_rxmap, .rx_empty,
    .hdr_rtn_valid, .hdr_rtn_vc_id, .hdr_rtn_fc,
    .data_rtn_valid, .data_rtn_vc_id, .data_rtn_fc,
    .hdr_rtn_v, .hdr_rtn_vc, .data_rtn_v, .data_rtn_vc, .rx_empty_seen
  );

  // --------------------
  // Header and data banks

  crd_counter_bank #(
    .NUM_VCS(NUM_VCS), .CNT_W(CNT_W), .inc_t(hdr_rtn_t), .dec_t(hdr_use_t)
  ) u_hdr_bank (
    .clk_gated, .rst_b, .tx_sm_disconnected, .rx_empty_seen,
    .rtn_v(hdr_rtn_v), .rtn_vc(hdr_rtn_vc), .rtn_fc(hdr_rtn_fc),
    .rtn_value(hdr_rtn_value),
    .use_v(tx_hcrd_consume_v), .use_vc(tx_hcrd_consume_vc),
    .use_fc(tx_hcrd_consume_fc), .use_value(tx_hcrd_consume_val),
    .crd_cnt(hcrd_cnt), .crd_inf(hcrd_inf),
    .has_consumed(h_has_consumed), .used_xflow(tx_hcrds_used_xflow)
  );

  crd_counter_bank #(
    .NUM_VCS(NUM_VCS), .CNT_W(CNT_W), .inc_t(data_rtn_t), .dec_t(data_use_t)
  ) u_data_bank (
    .clk_gated, .rst_b, .tx_sm_disconnected, .rx_empty_seen,
    .rtn_v(data_rtn_v), .rtn_vc(data_rtn_vc), .rtn_fc(data_rtn_fc),
    .rtn_value(data_rtn_value),
    .use_v(tx_dcrd_consume_v), .use_vc(tx_dcrd_consume_vc),
    .use_fc(tx_dcrd_consume_fc), .use_value(tx_dcrd_consume_val),
    .crd_cnt(dcrd_cnt), .crd_inf(dcrd_inf),
    .has_consumed(d_has_consumed), .used_xflow(tx_dcrds_used_xflow)
  );

  // --------------------
  // Outputs and minimum check

  crd_min_check #(.NUM_VCS(NUM_VCS), .CNT_W(CNT_W)) u_min_check (
    .clk_gated, .rst_b, .rx_empty_seen,
    .hcrd_cnt, .dcrd_cnt, .hcrd_inf, .dcrd_inf, .h_has_consumed, .d_has_consumed,
    .tx_hcrds_avail, .tx_dcrds_avail, .tx_has_consumed_crds, .tx_min_crds_rcvd
  );

endmodule

// File: test/crd_tx_table.svh
`ifndef CRD_TX_TABLE_SVH
`define CRD_TX_TABLE_SVH

// Columns, left to right
//   disc rx_empty | hdr rtn: v ext_vc fc val | data rtn: v ext_vc fc val
//   hdr use: v vc fc | data use: v vc fc val | cnt check: kind vc fc exp
//   flag check: sel exp
// Check kind 0 none, 1 hdr avail, 2 data avail
// Flag sel 0 none, 1 has_consumed, 2 min_crds, 3 hdr xflow, 4 data xflow
typedef struct packed {
  logic       disc;
  logic       rxe;
  logic       hv;
  logic [4:0] hvc;
  logic [1:0] hfc;
  logic [3:0] hval;
  logic       dv;
  logic [4:0] dvc;
  logic [1:0] dfc;
  logic [3:0] dval;
  logic       hcv;
  logic       hcvc;
  logic [1:0] hcfc;
  logic       dcv;
  logic       dcvc;
  logic [1:0] dcfc;
  logic [2:0] dcval;
  logic [1:0] chk;
  logic       cvc;
  logic [1:0] cfc;
  logic [7:0] exp_cnt;
  logic [2:0] fsel;
  logic       exp_flag;
} row_t;

localparam int NUM_ROWS = 22;

localparam row_t ROWS [NUM_ROWS] = '{
  '{0,0, 1,0,0,5, 1,0,0,3, 0,0,0, 0,0,0,0, 1,0,0,0,   1,0},
  '{0,0, 1,2,0,7, 1,9,1,6, 0,0,0, 0,0,0,0, 2,0,0,0,   0,0},
  '{0,0, 1,3,1,2, 1,1,1,4, 0,0,0, 0,0,0,0, 0,0,0,0,   0,0},
  '{0,0, 1,1,2,0, 1,1,2,8, 0,0,0, 0,0,0,0, 0,0,0,0,   0,0},
  '{0,0, 1,0,1,1, 1,0,1,4, 0,0,0, 0,0,0,0, 0,0,0,0,   0,0},
  '{0,0, 1,0,2,3, 1,0,2,0, 0,0,0, 0,0,0,0, 0,0,0,0,   0,0},
  '{0,0, 1,1,0,6, 1,3,0,5, 0,0,0, 0,0,0,0, 0,0,0,0,   0,0},
  '{0,1, 0,0,0,0, 1,0,0,2, 0,0,0, 0,0,0,0, 2,0,0,5,   2,0},
  '{0,0, 0,0,0,0, 0,0,0,0, 0,0,0, 0,0,0,0, 1,1,1,2,   2,1},
  '{0,0, 0,0,0,0, 0,0,0,0, 0,0,0, 0,0,0,0, 1,1,2,255, 2,1},
  '{0,0, 0,0,0,0, 0,0,0,0, 1,1,2, 1,0,2,4, 1,1,2,255, 1,0},
  '{0,0, 0,0,0,0, 0,0,0,0, 1,0,0, 1,0,0,3, 2,0,0,2,   1,1},
  '{0,0, 0,0,0,0, 0,0,0,0, 0,0,0, 0,0,0,0, 1,0,0,4,   2,0},
  '{0,0, 1,0,0,1, 1,0,0,2, 0,0,0, 0,0,0,0, 2,0,0,4,   1,1},
  '{0,0, 0,0,0,0, 1,0,0,1, 0,0,0, 0,0,0,0, 2,0,0,5,   1,0},
  '{0,0, 0,0,0,0, 0,0,0,0, 0,0,0, 0,0,0,0, 1,0,0,5,   2,1},
  '{0,0, 1,0,1,2, 0,0,0,0, 0,0,0, 0,0,0,0, 1,0,1,3,   3,1},
  '{0,0, 0,0,0,0, 0,0,0,0, 0,0,0, 0,0,0,0, 1,0,1,3,   3,0},
  '{0,0, 0,0,0,0, 0,0,0,0, 0,0,0, 0,0,0,0, 0,0,0,0,   1,1},
  '{1,0, 0,0,0,0, 0,0,0,0, 0,0,0, 0,0,0,0, 1,0,0,0,   2,1},
  '{1,0, 0,0,0,0, 0,0,0,0, 0,0,0, 0,0,0,0, 2,1,1,0,   2,0},
  '{0,0, 0,0,0,0, 1,1,1,9, 0,0,0, 0,0,0,0, 2,1,1,0,   4,0}
};

`endif

// File: test/tb_crd_tx.sv
module tb_crd_tx
  import crd_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_VCS = 2;
  localparam int CNT_W   = 8;
  localparam int VC_W    = 1;
  localparam int CNT_MAX = (1 << CNT_W) - 1;

  `include "crd_tx_table.svh"

  logic clk_gated;
  logic rst_b;
  logic tx_sm_disconnected;
  rxmap_t cfg_vc_rxmap;
  logic rx_empty;
  logic hdr_rtn_valid;
  ext_vc_t hdr_rtn_vc_id;
  fc_id_t hdr_rtn_fc;
  hdr_rtn_t hdr_rtn_value;
  logic data_rtn_valid;
  ext_vc_t data_rtn_vc_id;
  fc_id_t data_rtn_fc;
  data_rtn_t data_rtn_value;
  logic tx_hcrd_consume_v;
  logic [VC_W-1:0] tx_hcrd_consume_vc;
  fc_id_t tx_hcrd_consume_fc;
  hdr_use_t tx_hcrd_consume_val;
  logic tx_dcrd_consume_v;
  logic [VC_W-1:0] tx_dcrd_consume_vc;
  fc_id_t tx_dcrd_consume_fc;
  data_use_t tx_dcrd_consume_val;
  logic [NUM_VCS-1:0][NUM_FC-1:0][CNT_W-1:0] tx_hcrds_avail;
  logic [NUM_VCS-1:0][NUM_FC-1:0][CNT_W-1:0] tx_dcrds_avail;
  logic tx_has_consumed_crds;
  logic tx_min_crds_rcvd;
  logic tx_hcrds_used_xflow;
  logic tx_dcrds_used_xflow;

  // Reference model, kind 0 is header and kind 1 is data
  int m_cnt [2][NUM_VCS][NUM_FC];
  bit m_inf [2][NUM_VCS][NUM_FC];
  int m_cons [2][NUM_VCS][NUM_FC];
  bit m_carry [2][NUM_VCS][NUM_FC];
  bit m_seen;
  bit m_min;
  bit done;

  crd_tx_top #(.NUM_VCS(NUM_VCS), .CNT_W(CNT_W)) DUT (.*);

  initial begin
    clk_gated = 1'b0;
    forever #4 clk_gated = ~clk_gated;
  end

  // --------------------
  // Compare tasks

  task automatic check_cnt(string what, logic [CNT_W-1:0] got, logic [CNT_W-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t ns: %s got %0d expected %0d", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "credit count mismatch");
    end
  endtask

  task automatic check_flag(string what, logic got, logic exp);
    if (got !== exp) begin
      $display("FAIL %0t ns: %s got %b expected %b", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "flag mismatch");
    end
  endtask

  // Available value as the link rules define it
  function automatic int avail_of(int k, int v, int f);
    if (!m_seen) begin
      return 0;
    end
    return m_inf[k][v][f] ? CNT_MAX : m_cnt[k][v][f];
  endfunction

  // Map nibble lookup, external VC must be below 8 with valid bit set
  function automatic bit map_ok(logic valid, ext_vc_t ext);
    return valid && (ext < 8) && cfg_vc_rxmap[ext[2:0] * 4 + MAP_VALID_BIT];
  endfunction

  function automatic int map_vc(ext_vc_t ext);
    return (cfg_vc_rxmap >> (ext[2:0] * 4)) & ((1 << VC_W) - 1);
  endfunction

  // --------------------
  // Model step at one clock edge

  task automatic model_step();
    bit min_n;
    bit rok [2];
    int rvc [2];
    int rfc [2];
    int rval [2];
    bit uv [2];
    int uvc [2];
    int ufc [2];
    int uval [2];
    int inc;
    int dec;
    int s;
    rok[0] = map_ok(hdr_rtn_valid, hdr_rtn_vc_id);
    rok[1] = map_ok(data_rtn_valid, data_rtn_vc_id);
    rvc[0] = map_vc(hdr_rtn_vc_id);
    rvc[1] = map_vc(data_rtn_vc_id);
    rfc[0] = hdr_rtn_fc;
    rfc[1] = data_rtn_fc;
    rval[0] = hdr_rtn_value;
    rval[1] = data_rtn_value;
    uv[0] = tx_hcrd_consume_v;
    uv[1] = tx_dcrd_consume_v;
    uvc[0] = tx_hcrd_consume_vc;
    uvc[1] = tx_dcrd_consume_vc;
    ufc[0] = tx_hcrd_consume_fc;
    ufc[1] = tx_dcrd_consume_fc;
    uval[0] = tx_hcrd_consume_val;
    uval[1] = tx_dcrd_consume_val;
    // Minimum flag looks at state before this edge
    min_n = m_seen;
    for (int v = 0; v < NUM_VCS; v++) begin
      for (int f = 0; f < NUM_FC; f++) begin
        if (avail_of(0, v, f) == 0 || avail_of(1, v, f) < MIN_DATA_CRD) begin
          min_n = 0;
        end
      end
    end
    for (int k = 0; k < 2; k++) begin
      for (int v = 0; v < NUM_VCS; v++) begin
        for (int f = 0; f < NUM_FC; f++) begin
          inc = 0;
          dec = 0;
          m_carry[k][v][f] = 0;
          // Consume sees the infinite flag from before this edge
          if (uv[k] && uvc[k] == v && ufc[k] == f && !m_inf[k][v][f]) begin
            dec = uval[k];
          end
          if (rok[k] && rvc[k] == v && rfc[k] == f && !m_inf[k][v][f]) begin
            inc = rval[k];
            if (rval[k] == 0) begin
              m_inf[k][v][f] = 1;
            end
          end
          if (tx_sm_disconnected) begin
            m_cnt[k][v][f] = 0;
          end else begin
            s = m_cnt[k][v][f] + inc - dec;
            m_cnt[k][v][f] = (s > CNT_MAX) ? CNT_MAX : s;
            // Returns count against consumes only after rx_empty
            s = m_cons[k][v][f] + dec - (m_seen ? inc : 0);
            m_carry[k][v][f] = (s < 0) || (s > CNT_MAX);
            m_cons[k][v][f] = s & CNT_MAX;
          end
        end
      end
    end
    if (tx_sm_disconnected) begin
      m_seen = 0;
    end else if (rx_empty) begin
      m_seen = 1;
    end
    m_min = min_n;
  endtask

  // Every output against the model
  task automatic check_all();
    bit cons_any;
    bit hx;
    bit dx;
    cons_any = 0;
    hx = 0;
    dx = 0;
    for (int v = 0; v < NUM_VCS; v++) begin
      for (int f = 0; f < NUM_FC; f++) begin
        check_cnt($sformatf("hdr avail vc%0d fc%0d", v, f), tx_hcrds_avail[v][f],
                  CNT_W'(avail_of(0, v, f)));
        check_cnt($sformatf("data avail vc%0d fc%0d", v, f), tx_dcrds_avail[v][f],
                  CNT_W'(avail_of(1, v, f)));
        cons_any |= (m_cons[0][v][f] != 0) || (m_cons[1][v][f] != 0);
        hx |= m_carry[0][v][f];
        dx |= m_carry[1][v][f];
      end
    end
    check_flag("has_consumed", tx_has_consumed_crds, cons_any);
    check_flag("min_crds_rcvd", tx_min_crds_rcvd, m_min);
    check_flag("hdr xflow", tx_hcrds_used_xflow, hx);
    check_flag("data xflow", tx_dcrds_used_xflow, dx);
  endtask

  task automatic drive_row(row_t r);
    tx_sm_disconnected = r.disc;
    rx_empty = r.rxe;
    hdr_rtn_valid = r.hv;
    hdr_rtn_vc_id = r.hvc;
    hdr_rtn_fc = r.hfc;
    hdr_rtn_value = r.hval;
    data_rtn_valid = r.dv;
    data_rtn_vc_id = r.dvc;
    data_rtn_fc = r.dfc;
    data_rtn_value = r.dval;
    tx_hcrd_consume_v = r.hcv;
    tx_hcrd_consume_vc = r.hcvc;
    tx_hcrd_consume_fc = r.hcfc;
    tx_hcrd_consume_val = r.hcv;
    tx_dcrd_consume_v = r.dcv;
    tx_dcrd_consume_vc = r.dcvc;
    tx_dcrd_consume_fc = r.dcfc;
    tx_dcrd_consume_val = r.dcval;
  endtask

  // One cycle, inputs already driven 1 ns after the previous edge
  task automatic clock_and_check();
    @(posedge clk_gated);
    model_step();
    #1;
    check_all();
  endtask

  // Row level expectation on top of the model
  task automatic check_row(int i, row_t r);
    logic fval;
    if (r.chk == 2'd1) begin
      check_cnt($sformatf("row %0d hdr avail", i), tx_hcrds_avail[r.cvc][r.cfc], r.exp_cnt);
    end else if (r.chk == 2'd2) begin
      check_cnt($sformatf("row %0d data avail", i), tx_dcrds_avail[r.cvc][r.cfc], r.exp_cnt);
    end
    if (r.fsel != 3'd0) begin
      case (r.fsel)
        3'd1: fval = tx_has_consumed_crds;
        3'd2: fval = tx_min_crds_rcvd;
        3'd3: fval = tx_hcrds_used_xflow;
        // Select 4, data xflow
        default: fval = tx_dcrds_used_xflow;
      endcase
      check_flag($sformatf("row %0d flag %0d", i, r.fsel), fval, r.exp_flag);
    end
  endtask

  // Guards every edge wait of the run
  initial begin : watchdog
    int n;
    n = 0;
    while (n < 2000 && !done) begin
      @(posedge clk_gated);
      n++;
    end
    if (!done) begin
      $display("Run did not finish within 2000 clock cycles");
      $display("** FAIL **");
      $fatal(1, "timeout");
    end
  end

  initial begin
    row_t r;
    void'($urandom(26619));
    done = 0;
    m_seen = 0;
    m_min = 0;
    for (int k = 0; k < 2; k++) begin
      for (int v = 0; v < NUM_VCS; v++) begin
        for (int f = 0; f < NUM_FC; f++) begin
          m_cnt[k][v][f] = 0;
          m_inf[k][v][f] = 0;
          m_cons[k][v][f] = 0;
          m_carry[k][v][f] = 0;
        end
      end
    end
    rst_b = 1'b0;
    // Ext 0 to vc0, ext 1 and 3 to vc1, ext 2 not valid
    cfg_vc_rxmap = 32'h0000_9198;
    drive_row('0);
    repeat (3) @(posedge clk_gated);
    #1;
    rst_b = 1'b1;
    check_all();

    // --------------------
    // Directed table
    for (int i = 0; i < NUM_ROWS; i++) begin
      r = ROWS[i];
      drive_row(r);
      clock_and_check();
      check_row(i, r);
    end

    // --------------------
    // Random returns, header pinned to vc0 fc0 to reach saturation
    for (int i = 0; i < 48; i++) begin
      drive_row('0);
      rx_empty = (i == 40);
      hdr_rtn_valid = 1'b1;
      hdr_rtn_vc_id = '0;
      hdr_rtn_fc = '0;
      hdr_rtn_value = hdr_rtn_t'($urandom_range(15, 8));
      data_rtn_valid = 1'b1;
      data_rtn_vc_id = ext_vc_t'($urandom_range(4, 0));
      data_rtn_fc = fc_id_t'($urandom_range(2, 0));
      data_rtn_value = data_rtn_t'($urandom_range(15, 1));
      clock_and_check();
    end
    check_cnt("saturated hdr avail vc0 fc0", tx_hcrds_avail[0][0], '1);

    done = 1;
    $display("** PASS **");
    $finish;
  end

endmodule

// File: sim.f
+incdir+test
hw/crd_pkg.sv
hw/crd_rtn_decode.sv
hw/crd_counter_bank.sv
hw/crd_min_check.sv
hw/crd_tx_top.sv
test/tb_crd_tx.sv

// File: Bender.yml
package:
  name: crd_tx

sources:
  - files:
      - hw/crd_pkg.sv
      - hw/crd_rtn_decode.sv
      - hw/crd_counter_bank.sv
      - hw/crd_min_check.sv
      - hw/crd_tx_top.sv
  - target: simulation
    include_dirs:
      - test
    files:
      - test/tb_crd_tx.sv
